/* voice_fx.f */
source/voice_fx_pkg.sv
source/user_controls.sv
source/noise_gate.sv
source/echo_effect.sv
source/output_gain.sv
source/voice_fx_top.sv
verification/voice_fx_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary -Wno-fatal --top-module voice_fx_tb -f voice_fx.f -o voice_fx_sim
./obj_dir/voice_fx_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test passed$" sim.log; then
   echo "simulation ok"
else
   echo "simulation reported a failure"
   exit 1
fi

/* verification/voice_fx_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module voice_fx_tb;

   localparam int DB_CYCLES = 8;     // short debounce for simulation
   localparam int DEPTH     = 4;     // echo delay in samples
   localparam int THRESHOLD = 256;
   localparam int HOLD      = 4;

   typedef enum int {K_PRESS, K_GLITCH, K_LEVEL, K_KNOB, K_SKIP, K_BURST, K_LOUD} kind_t;

   typedef struct {
      kind_t kind;
      int    value;  // button, ptt level, knob steps or sample count
      int    exp;    // expected status, or out_valid count for bursts
   } row_t;

   logic                  clk;
   logic                  rst;
   logic [3:0]            pbs;
   logic [1:0]            vol;
   voice_fx_pkg::sample_t in_sample;
   logic                  in_valid;
   voice_fx_pkg::sample_t out_sample;
   logic                  out_valid;
   voice_fx_pkg::ctrl_t   status;

   row_t                  rows[$];
   voice_fx_pkg::sample_t exp_q[$];       // predicted outputs in order
   int                    cyc_q[$];       // drive cycle of each predicted output
   int                    cyc = 0;
   int                    strobes = 0;
   int                    errors = 0;
   int                    checks = 0;
   bit                    timed_out = 0;
   integer                seed;
   voice_fx_pkg::quad_t   knob;           // knob state being driven
   voice_fx_pkg::ctrl_t   model_ctrl;     // predicted control word
   voice_fx_pkg::sample_t hist [DEPTH];   // model echo history
   int                    wp;
   int                    m_hold;         // model gate hold count
   voice_fx_pkg::sample_t mon_exp;
   int                    mon_cyc;

   voice_fx_top #(
      .DEBOUNCE_CYCLES (16'(DB_CYCLES)),
      .GATE_THRESHOLD  (16'(THRESHOLD)),
      .GATE_HOLD       (16'(HOLD)),
      .ECHO_DEPTH      (DEPTH)
   ) i_dut (
      .clk        (clk),
      .rst        (rst),
      .pbs        (pbs),
      .vol        (vol),
      .in_sample  (in_sample),
      .in_valid   (in_valid),
      .out_sample (out_sample),
      .out_valid  (out_valid),
      .status     (status)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   always @(posedge clk) cyc <= cyc + 1;

   task automatic check(input string name, input int got, input int exp);
      checks++;
      if (got !== exp) begin
         $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic add_row(input kind_t kind, input int value, input int exp);
      row_t r;
      r.kind  = kind;
      r.value = value;
      r.exp   = exp;
      rows.push_back(r);
   endtask

   task automatic idle(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic wait_status(input int exp);
      int n;
      n = 0;
      while (int'(status) != exp && n < DB_CYCLES + 40) begin
         idle(1);
         n++;
      end
      if (int'(status) != exp) begin
         $display("Timeout: status never settled to %0h", exp);
         timed_out = 1'b1;
      end
      check("status", int'(status), exp);
   endtask

   function automatic voice_fx_pkg::quad_t next_quad(input voice_fx_pkg::quad_t q, input bit cw);
      case (q)
         voice_fx_pkg::Q00: return cw ? voice_fx_pkg::Q01 : voice_fx_pkg::Q10;
         voice_fx_pkg::Q01: return cw ? voice_fx_pkg::Q11 : voice_fx_pkg::Q00;
         voice_fx_pkg::Q11: return cw ? voice_fx_pkg::Q10 : voice_fx_pkg::Q01;
         default:           return cw ? voice_fx_pkg::Q00 : voice_fx_pkg::Q11;
      endcase
   endfunction

   task automatic turn_knob(input int steps);
      bit cw;
      cw = steps > 0;
      repeat (cw ? steps : -steps) begin
         knob = next_quad(knob, cw);
         vol  = knob;
         idle(4);                                        // a few cycles per state
         if (cw && model_ctrl.volume != 4'd15) model_ctrl.volume = model_ctrl.volume + 4'd1;
         if (!cw && model_ctrl.volume != 4'd0) model_ctrl.volume = model_ctrl.volume - 4'd1;
      end
   endtask

   task automatic press(input int b);
      pbs[b] = 1'b1;
      idle(20);
      pbs[b] = 1'b0;
      idle(DB_CYCLES + 8);                               // let the release settle too
      if (b == 1) model_ctrl.mute = ~model_ctrl.mute;
      if (b == 2) model_ctrl.effect = ~model_ctrl.effect;
      if (b == 3) model_ctrl.noise_gate = ~model_ctrl.noise_gate;
   endtask

   // gate, echo and gain rules applied to one valid sample
   task automatic predict(input voice_fx_pkg::sample_t x, output voice_fx_pkg::sample_t y);
      int mag;
      int d;
      int s;
      int v;
      bit loud;
      voice_fx_pkg::sample_t g;
      mag  = (x < 0) ? -int'(x) : int'(x);
      loud = mag >= THRESHOLD;
      g    = (!model_ctrl.noise_gate || loud || m_hold != 0) ? x : 16'sd0;
      if (loud) m_hold = HOLD;
      else if (m_hold > 0) m_hold--;
      d = hist[wp];                                      // sample DEPTH valids back
      hist[wp] = g;
      wp = (wp + 1) % DEPTH;
      s = model_ctrl.effect ? int'(g) + (d >>> 1) : int'(g);
      if (s > 32767) s = 32767;
      if (s < -32768) s = -32768;
      v = int'(model_ctrl.volume);
      y = (model_ctrl.mute || !model_ctrl.ptt) ? 16'sd0 : 16'((s * v) >>> 4);
   endtask

   task automatic send_burst(input int count, input bit loud_only);
      int r;
      int n;
      voice_fx_pkg::sample_t x;
      voice_fx_pkg::sample_t y;
      for (int i = 0; i < count; i++) begin
         r = $random(seed);
         if (!loud_only && r[30:28] == 3'd0) begin
            in_valid = 1'b0;                             // occasional idle gap
            idle(1);
         end
         if (loud_only) begin
            x = 16'(32000 + (r & 511));                  // near full scale
            if (r[20]) x = -x;
         end else if (r[1:0] == 2'd0) begin
            x = 16'(r >>> 16);                           // mostly loud
         end else begin
            x = 16'(r % 200);                            // below the gate threshold
         end
         in_sample = x;
         in_valid  = 1'b1;
         predict(x, y);
         exp_q.push_back(y);
         cyc_q.push_back(cyc);
         idle(1);
      end
      in_valid = 1'b0;
      n = 0;
      while (exp_q.size() != 0 && n < 20) begin
         idle(1);
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("Timeout: %0d samples never came out", exp_q.size());
         timed_out = 1'b1;
      end
   endtask

   // outputs are stable at the falling edge
   always @(negedge clk) begin
      if (!rst && out_valid) begin
         strobes++;
         if (exp_q.size() == 0) begin
            $display("Error at %0t ns: out_valid with no sample outstanding", $time);
            errors++;
         end else begin
            mon_exp = exp_q.pop_front();
            mon_cyc = cyc_q.pop_front();
            check("out_sample", int'(out_sample), int'(mon_exp));
            check("out_valid latency", cyc - mon_cyc, 3);
         end
      end
   end

   initial begin
      row_t row;
      int   start;
      int   done;
      seed = 77610;
      rst = 1'b1;
      pbs = '0;
      vol = '0;
      in_sample = '0;
      in_valid = 1'b0;
      knob = voice_fx_pkg::Q00;
      model_ctrl = '0;
      wp = 0;
      m_hold = 0;
      done = 0;
      for (int i = 0; i < DEPTH; i++) hist[i] = '0;

      add_row(K_GLITCH, 1, 'h00);                        // shorter than debounce
      add_row(K_PRESS, 1, 'h40);
      add_row(K_PRESS, 2, 'h60);
      add_row(K_PRESS, 3, 'h70);
      add_row(K_PRESS, 1, 'h30);
      add_row(K_PRESS, 2, 'h10);
      add_row(K_PRESS, 3, 'h00);
      add_row(K_KNOB, 5, 'h05);
      add_row(K_SKIP, 0, 'h05);
      add_row(K_KNOB, 14, 'h0f);                         // saturates at 15
      add_row(K_KNOB, -3, 'h0c);
      add_row(K_SKIP, 0, 'h0c);
      add_row(K_KNOB, -20, 'h00);                        // saturates at 0
      add_row(K_KNOB, 15, 'h0f);
      add_row(K_BURST, 8, 8);                            // talk released
      add_row(K_LEVEL, 1, 'h8f);
      add_row(K_BURST, 24, 24);
      add_row(K_PRESS, 1, 'hcf);
      add_row(K_BURST, 8, 8);                            // muted while talking
      add_row(K_PRESS, 1, 'h8f);
      add_row(K_PRESS, 3, 'h9f);
      add_row(K_BURST, 32, 32);                          // gate on
      add_row(K_PRESS, 3, 'h8f);
      add_row(K_PRESS, 2, 'haf);
      add_row(K_BURST, 32, 32);                          // echo on
      add_row(K_LOUD, 16, 16);
      add_row(K_PRESS, 3, 'hbf);
      add_row(K_BURST, 24, 24);
      add_row(K_LOUD, 8, 8);
      add_row(K_LEVEL, 0, 'h3f);
      add_row(K_BURST, 8, 8);

      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      idle(4);
      check("status after reset", int'(status), 0);

      for (int i = 0; i < rows.size(); i++) begin
         if (timed_out) break;
         row = rows[i];
         start = strobes;
         case (row.kind)
            K_PRESS:  press(row.value);
            K_GLITCH: begin
               pbs[row.value] = 1'b1;
               idle(3);
               pbs[row.value] = 1'b0;
               idle(DB_CYCLES + 10);
            end
            K_LEVEL: begin
               pbs[0] = row.value[0];
               model_ctrl.ptt = row.value[0];
               idle(DB_CYCLES + 8);
            end
            K_KNOB: turn_knob(row.value);
            K_SKIP: begin
               knob = voice_fx_pkg::quad_t'(knob ^ 2'b11);   // diagonal jump, no step
               vol  = knob;
               idle(4);
            end
            default: send_burst(row.value, row.kind == K_LOUD);
         endcase
         if (row.kind == K_BURST || row.kind == K_LOUD) begin
            check("out_valid count", strobes - start, row.exp);
         end else begin
            wait_status(row.exp);
         end
         done++;
         $display("test %0d %s done, %0d errors so far", i, row.kind.name(), errors);
      end

      if (timed_out) errors++;
      $display("%0d of %0d tests run, %0d checks, %0d errors", done, rows.size(), checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule : voice_fx_tb

`default_nettype wire

/* source/voice_fx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module voice_fx_top #(
   parameter voice_fx_pkg::count_t  DEBOUNCE_CYCLES = 16'd5000, // button settle time in cycles
   parameter voice_fx_pkg::sample_t GATE_THRESHOLD  = 16'sd256, // gate opening level
   parameter voice_fx_pkg::count_t  GATE_HOLD       = 16'd4,    // gate hold in samples
   parameter int                    ECHO_DEPTH      = 16        // echo delay in samples
) (
   input  wire                        clk,
   input  wire                        rst,
   input  wire  [3:0]                 pbs,         // push-buttons
   input  wire  [1:0]                 vol,         // volume knob
   input  wire voice_fx_pkg::sample_t in_sample,
   input  wire                        in_valid,
   output voice_fx_pkg::sample_t      out_sample,
   output logic                       out_valid,
   output voice_fx_pkg::ctrl_t        status       // live control word
);

   voice_fx_pkg::ctrl_t   ctrl;         // shared by all three stages
   voice_fx_pkg::sample_t gate_sample;  // gate to echo
   logic                  gate_valid;
   voice_fx_pkg::sample_t echo_sample;  // echo to gain
   logic                  echo_valid;

   user_controls #(
      .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
   ) i_user_controls (
      .clk  (clk),
      .rst  (rst),
      .pbs  (pbs),
      .vol  (vol),
      .ctrl (ctrl)
   );

   noise_gate #(
      .GATE_THRESHOLD (GATE_THRESHOLD),
      .GATE_HOLD      (GATE_HOLD)
   ) i_noise_gate (
      .clk        (clk),
      .rst        (rst),
      .in_sample  (in_sample),
      .in_valid   (in_valid),
      .ctrl       (ctrl),
      .out_sample (gate_sample),
      .out_valid  (gate_valid)
   );

   echo_effect #(
      .ECHO_DEPTH (ECHO_DEPTH)
   ) i_echo_effect (
      .clk        (clk),
      .rst        (rst),
      .in_sample  (gate_sample),
      .in_valid   (gate_valid),
      .ctrl       (ctrl),
      .out_sample (echo_sample),
      .out_valid  (echo_valid)
   );

   output_gain i_output_gain (
      .clk        (clk),
      .rst        (rst),
      .in_sample  (echo_sample),
      .in_valid   (echo_valid),
      .ctrl       (ctrl),
      .out_sample (out_sample),
      .out_valid  (out_valid)
   );

   assign status = ctrl;

endmodule : voice_fx_top

`default_nettype wire

/* source/output_gain.sv */
`timescale 1ns/10ps
`default_nettype none

module output_gain (
   input  wire                        clk,
   input  wire                        rst,
   input  wire voice_fx_pkg::sample_t in_sample,
   input  wire                        in_valid,
   input  wire voice_fx_pkg::ctrl_t   ctrl,
   output voice_fx_pkg::sample_t      out_sample,
   output logic                       out_valid
);

   logic signed [4:0]     gain;     // volume with a zero sign bit
   logic signed [20:0]    product;  // sample times volume, full width
   voice_fx_pkg::sample_t scaled;   // product over 16
   logic                  silent;   // muted or talk released

   assign gain    = $signed({1'b0, ctrl.volume});
   assign product = in_sample * gain;

   // divide by 16, 15/16 of full scale always fits
   assign scaled = product[19:4];

   assign silent = ctrl.mute || !ctrl.ptt;

   // stage register
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         if (silent) begin
            out_sample <= '0;
         end else begin
            out_sample <= scaled;
         end
      end
   end

endmodule : output_gain

`default_nettype wire

/* source/echo_effect.sv */
`timescale 1ns/10ps
`default_nettype none

module echo_effect #(
   parameter int ECHO_DEPTH = 16   // delay in valid samples
) (
   input  wire                        clk,
   input  wire                        rst,
   input  wire voice_fx_pkg::sample_t in_sample,
   input  wire                        in_valid,
   input  wire voice_fx_pkg::ctrl_t   ctrl,
   output voice_fx_pkg::sample_t      out_sample,
   output logic                       out_valid
);

   localparam int PTR_W = (ECHO_DEPTH > 1) ? $clog2(ECHO_DEPTH) : 1;

   voice_fx_pkg::sample_t delay_mem [ECHO_DEPTH];  // circular history of past samples
   logic [PTR_W-1:0]      wr_ptr;                  // oldest entry, overwritten next
   voice_fx_pkg::sample_t delayed;                 // sample ECHO_DEPTH valids ago
   voice_fx_pkg::sample_t echo_half;               // delayed sample at half level
   logic signed [16:0]    mix_sum;                 // one spare bit for overflow
   voice_fx_pkg::sample_t mix_sat;                 // sum clipped to sample range

   assign delayed   = delay_mem[wr_ptr];
   assign echo_half = delayed >>> 1;   // arithmetic, keeps the sign

   assign mix_sum = {in_sample[15], in_sample} + {echo_half[15], echo_half};

   // clip when the two top bits disagree
   always_comb begin
      if (mix_sum[16] != mix_sum[15]) begin
         if (mix_sum[16]) begin
            mix_sat = 16'sh8000;   // negative full scale
         end else begin
            mix_sat = 16'sh7fff;   // positive full scale
         end
      end else begin
         mix_sat = mix_sum[15:0];
      end
   end

   // delay line runs on every valid, effect on or off
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         for (int i = 0; i < ECHO_DEPTH; i++) begin
            delay_mem[i] <= '0;
         end
      end else if (in_valid) begin
         delay_mem[wr_ptr] <= in_sample;   // replaces the entry just read
         if (wr_ptr == PTR_W'(ECHO_DEPTH - 1)) begin
            wr_ptr <= '0;
         end else begin
            wr_ptr <= wr_ptr + 1'b1;
         end
      end
   end

   // stage register
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         out_sample <= ctrl.effect ? mix_sat : in_sample;
      end
   end

endmodule : echo_effect

`default_nettype wire

/* source/noise_gate.sv */
`timescale 1ns/10ps
`default_nettype none

module noise_gate #(
   parameter voice_fx_pkg::sample_t GATE_THRESHOLD = 16'sd256, // loud at or above this magnitude
   parameter voice_fx_pkg::count_t  GATE_HOLD      = 16'd4     // samples kept open after a loud one
) (
   input  wire                    clk,
   input  wire                    rst,
   input  wire voice_fx_pkg::sample_t in_sample,
   input  wire                    in_valid,
   input  wire voice_fx_pkg::ctrl_t   ctrl,
   output voice_fx_pkg::sample_t  out_sample,
   output logic                   out_valid
);

   logic [15:0]          mag;        // unsigned magnitude, -32768 maps to 32768
   logic                 loud;       // sample reaches the threshold
   logic                 pass;       // sample allowed through the gate
   voice_fx_pkg::count_t hold_cnt;   // samples still open after the last loud one

   // magnitude of the incoming sample
   always_comb begin
      if (in_sample[15]) begin
         mag = $unsigned(~in_sample) + 16'd1;
      end else begin
         mag = $unsigned(in_sample);
      end
   end

   assign loud = (mag >= $unsigned(GATE_THRESHOLD));
   assign pass = loud || (hold_cnt != '0);   // hold count taken before this sample

   // hold counter tracks even with the gate off
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         hold_cnt <= '0;
      end else if (in_valid) begin
         if (loud) begin
            hold_cnt <= GATE_HOLD;
         end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 16'd1;
         end
      end
   end

   // stage register
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         out_sample <= (!ctrl.noise_gate || pass) ? in_sample : '0;   // quiet samples go silent
      end
   end

endmodule : noise_gate

`default_nettype wire

/* source/user_controls.sv */
`timescale 1ns/10ps
`default_nettype none

module user_controls #(
   parameter voice_fx_pkg::count_t DEBOUNCE_CYCLES = 16'd5000 // stable cycles before a change counts
) (
   input  wire                  clk,
   input  wire                  rst,
   input  wire  [3:0]           pbs,   // raw push-buttons, active high
   input  wire  [1:0]           vol,   // raw quadrature knob
   output voice_fx_pkg::ctrl_t  ctrl
);

   logic [3:0]           pbs_meta;       // first sync stage
   logic [3:0]           pbs_sync;       // second sync stage, safe to use
   logic [3:0]           pbs_db;         // debounced levels
   logic [3:0]           pbs_db_prev;    // debounced levels one cycle back
   logic [3:0]           pbs_rise;       // debounced rising edges
   voice_fx_pkg::count_t db_cnt [4];     // one debounce counter per button

   logic [1:0]           vol_meta;       // first knob sync stage
   voice_fx_pkg::quad_t  vol_sync;       // current synchronized knob state
   voice_fx_pkg::quad_t  vol_prev;       // knob state one cycle back
   logic                 step_cw;        // one clockwise step seen
   logic                 step_acw;       // one anticlockwise step seen

   // two flop synchronizers for buttons and knob
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         pbs_meta <= '0;
         pbs_sync <= '0;
         vol_meta <= '0;
         vol_sync <= voice_fx_pkg::Q00;
         vol_prev <= voice_fx_pkg::Q00;
      end else begin
         pbs_meta <= pbs;
         pbs_sync <= pbs_meta;
         vol_meta <= vol;
         vol_sync <= voice_fx_pkg::quad_t'(vol_meta);
         vol_prev <= vol_sync;   // previous state for the step decoder
      end
   end

   // per-button debounce on the synchronized level
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         pbs_db <= '0;
         for (int i = 0; i < 4; i++) begin
            db_cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (pbs_sync[i] == pbs_db[i]) begin
               db_cnt[i] <= '0;                      // input agrees, restart
            end else if (db_cnt[i] + 16'd1 >= DEBOUNCE_CYCLES) begin
               pbs_db[i] <= pbs_sync[i];              // held long enough, commit
               db_cnt[i] <= '0;
            end else begin
               db_cnt[i] <= db_cnt[i] + 16'd1;
            end
         end
      end
   end

   assign pbs_rise = pbs_db & ~pbs_db_prev;  // edge on the debounced level only

   // knob step decode, skipped states give no step
   always_comb begin
      step_cw  = 1'b0;
      step_acw = 1'b0;
      case ({vol_prev, vol_sync})
         {voice_fx_pkg::Q00, voice_fx_pkg::Q01},
         {voice_fx_pkg::Q01, voice_fx_pkg::Q11},
         {voice_fx_pkg::Q11, voice_fx_pkg::Q10},
         {voice_fx_pkg::Q10, voice_fx_pkg::Q00}: step_cw = 1'b1;
         {voice_fx_pkg::Q00, voice_fx_pkg::Q10},
         {voice_fx_pkg::Q10, voice_fx_pkg::Q11},
         {voice_fx_pkg::Q11, voice_fx_pkg::Q01},
         {voice_fx_pkg::Q01, voice_fx_pkg::Q00}: step_acw = 1'b1;
         default: ;                                   // no move or an illegal jump
      endcase
   end

   // toggles, ptt level and saturating volume
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         pbs_db_prev <= '0;
         ctrl        <= '0;
      end else begin
         pbs_db_prev     <= pbs_db;
         ctrl.ptt        <= pbs_db[0];                      // level, not a toggle
         ctrl.mute       <= ctrl.mute ^ pbs_rise[1];
         ctrl.effect     <= ctrl.effect ^ pbs_rise[2];
         ctrl.noise_gate <= ctrl.noise_gate ^ pbs_rise[3];
         if (step_cw && ctrl.volume != 4'd15) begin
            ctrl.volume <= ctrl.volume + 4'd1;              // stops at full scale
         end else if (step_acw && ctrl.volume != 4'd0) begin
            ctrl.volume <= ctrl.volume - 4'd1;              // stops at silence
         end
      end
   end

endmodule : user_controls

`default_nettype wire

/* source/voice_fx_pkg.sv */
`default_nettype none

package voice_fx_pkg;

   // signed 16-bit audio sample, two's complement
   typedef logic signed [15:0] sample_t;

   // output volume step, 0 is silent and 15 is 15/16 gain
   typedef logic [3:0] volume_t;

   // debounce and gate hold counters
   typedef logic [15:0] count_t;

   // control word from the button and knob block, 8 bits in all
   typedef struct packed {
      logic    ptt;         // talk while button 0 held
      logic    mute;        // toggled by button 1
      logic    effect;      // echo enable, toggled by button 2
      logic    noise_gate;  // gate enable, toggled by button 3
      volume_t volume;      // knob position, saturating
   } ctrl_t;

   // knob states in clockwise gray order
   typedef enum logic [1:0] {
      Q00 = 2'b00,
      Q01 = 2'b01,
      Q11 = 2'b11,
      Q10 = 2'b10
   } quad_t;

endpackage : voice_fx_pkg

`default_nettype wire
